// File: Bender.yml
package:
  name: lsu_front_end

sources:
  - files:
      - common/lsq_pkg.sv
      - lsq/store_buffer.sv
      - lsq/load_store_queue.sv
      - source/mem_xcpt_check.sv
      - source/dtlb.sv
      - source/lsu_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_lsu_top.sv

// File: all.f
+incdir+dv
common/lsq_pkg.sv
lsq/store_buffer.sv
lsq/load_store_queue.sv
source/mem_xcpt_check.sv
source/dtlb.sv
source/lsu_top.sv
dv/tb_lsu_top.sv

// File: common/lsq_pkg.sv
/* Shared sizes, address map, instruction and TLB types
   and exception causes of the load-store unit */
package lsq_pkg;

    // Queue and TLB sizes
    localparam int LSQ_NUM_ENTRIES = 8;
    localparam int SB_NUM_ENTRIES  = 4;
    localparam int TLB_NUM_ENTRIES = 8;
    localparam int GL_INDEX_BITS   = 5;

    localparam int LSQ_PTR_BITS = $clog2(LSQ_NUM_ENTRIES);
    localparam int SB_PTR_BITS  = $clog2(SB_NUM_ENTRIES);
    localparam int TLB_PTR_BITS = $clog2(TLB_NUM_ENTRIES);

    // 32-bit addresses, 4 KiB pages
    localparam int ADDR_BITS        = 32;
    localparam int DATA_BITS        = 64;
    localparam int PAGE_OFFSET_BITS = 12;
    localparam int PN_BITS          = ADDR_BITS - PAGE_OFFSET_BITS;

    // Address map
    localparam logic [ADDR_BITS-1:0] UNMAPPED_ADDR_UPPER = 32'h0000_1000;
    localparam logic [ADDR_BITS-1:0] IO_ADDR_LOWER       = 32'h4000_0000;
    localparam logic [ADDR_BITS-1:0] IO_ADDR_UPPER       = 32'h8000_0000;
    localparam logic [ADDR_BITS-1:0] PHYS_MEM_LIMIT      = 32'h9000_0000;

    typedef logic [GL_INDEX_BITS-1:0]  gl_index_t;
    typedef logic [ADDR_BITS-1:0]      addr_t;
    typedef logic [DATA_BITS-1:0]      data_t;
    typedef logic [PN_BITS-1:0]        pn_t;
    typedef logic [LSQ_PTR_BITS-1:0]   lsq_ptr_t;
    typedef logic [LSQ_PTR_BITS:0]     lsq_cnt_t;
    typedef logic [SB_PTR_BITS-1:0]    sb_ptr_t;
    typedef logic [TLB_PTR_BITS-1:0]   tlb_ptr_t;

    typedef enum logic [1:0] {
        LOAD,
        STORE,
        AMO     // Handled as a store
    } mem_type_t;

    // RISC-V funct3 encoding of the access size
    typedef enum logic [2:0] {
        MEM_B  = 3'b000,
        MEM_H  = 3'b001,
        MEM_W  = 3'b010,
        MEM_D  = 3'b011,
        MEM_BU = 3'b100,
        MEM_HU = 3'b101,
        MEM_WU = 3'b110
    } mem_size_t;

    typedef enum logic [3:0] {
        LD_ADDR_MISALIGNED     = 4'd4,
        LD_ACCESS_FAULT        = 4'd5,
        ST_AMO_ADDR_MISALIGNED = 4'd6,
        ST_AMO_ACCESS_FAULT    = 4'd7,
        LD_PAGE_FAULT          = 4'd13,
        ST_AMO_PAGE_FAULT      = 4'd15
    } xcpt_cause_t;

    typedef struct packed {
        logic        valid;
        xcpt_cause_t cause;
        addr_t       origin;    // Virtual address of the access
    } xcpt_t;

    typedef struct packed {
        logic      valid;
        mem_type_t mem_type;
        mem_size_t mem_size;
        gl_index_t gl_index;
        addr_t     addr;
        data_t     data;       // Store data
        logic      translated;
        xcpt_t     xcpt;
    } mem_instr_t;

    typedef struct packed {
        logic valid;
        pn_t  vpn;
        logic store;
        logic translate;
    } tlb_req_t;

    typedef struct packed {
        logic hit;
        pn_t  ppn;
        logic ld_page_fault;
        logic st_page_fault;
    } tlb_resp_t;

    typedef struct packed {
        logic valid;
        pn_t  vpn;
        pn_t  ppn;
        logic readable;
        logic writable;
    } tlb_fill_t;

endpackage

// File: dv/lsu_ref.svh
/* Reference translation model, page map, scoreboard queue
   and typed compare tasks of the testbench */
`ifndef LSU_REF_SVH
`define LSU_REF_SVH

mem_instr_t exp_q[$];      // Expected issue order
pn_t        map_vpn[$];    // Pages installed in the TLB
pn_t        map_ppn[$];
logic       map_rd[$];
logic       map_wr[$];

function automatic int access_bytes(input mem_size_t size);
    case (size)
        MEM_H, MEM_HU: return 2;
        MEM_W, MEM_WU: return 4;
        MEM_D:         return 8;
        default:       return 1;
    endcase
endfunction

// Page map, then exception priority from the address rules
function automatic mem_instr_t ref_translate(input mem_instr_t in, input logic en);
    mem_instr_t r;
    logic       st;
    logic       rd;
    logic       wr;
    pn_t        ppn;
    r            = in;
    r.valid      = 1'b1;
    r.translated = 1'b1;
    r.xcpt       = '0;
    st           = in.mem_type != LOAD;
    rd           = 1'b0;
    wr           = 1'b0;
    ppn          = '0;
    if (en) begin
        for (int i = 0; i < map_vpn.size(); i++) begin
            if (map_vpn[i] == in.addr[31:12]) begin
                ppn = map_ppn[i];
                rd  = map_rd[i];
                wr  = map_wr[i];
            end
        end
        r.addr = {ppn, in.addr[11:0]};
    end
    r.xcpt.valid  = 1'b1;
    r.xcpt.origin = in.addr;
    if (in.addr % access_bytes(in.mem_size) != 0) begin
        r.xcpt.cause = st ? ST_AMO_ADDR_MISALIGNED : LD_ADDR_MISALIGNED;
    end else if (en && st && !wr) begin
        r.xcpt.cause = ST_AMO_PAGE_FAULT;
    end else if (en && !st && !rd) begin
        r.xcpt.cause = LD_PAGE_FAULT;
    end else if (!en && (in.addr < 32'h0000_1000 || in.addr >= 32'h9000_0000)) begin
        r.xcpt.cause = st ? ST_AMO_ACCESS_FAULT : LD_ACCESS_FAULT;
    end else begin
        r.xcpt = '0;
    end
    return r;
endfunction

task automatic check_instr(input string name, input mem_instr_t got, input mem_instr_t exp);
    if (got !== exp) begin
        $display("FAIL %s got %h expected %h", name, got, exp);
        report_fail("Issued instruction differs from the reference");
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("FAIL %s got %h expected %h", name, got, exp);
        report_fail("Status flag differs from the reference");
    end
endtask

`endif

// File: dv/tb_lsu_top.sv
`timescale 1ns/1ps
/* Testbench of the load-store front end: stimulus, TLB fill, commit acks,
   issue comparison against the reference model and watchdog */
module tb_lsu_top
    import lsq_pkg::*;
();

    localparam int TEST_INSTRS = 60;
    localparam int WATCHDOG_NS = 200 * TEST_INSTRS * 8;

    logic       clk_i;
    logic       rstn_i;
    logic       flush_i;
    logic       en_translation_i;
    mem_instr_t instr_i;
    logic       instr_ready_o;
    tlb_fill_t  tlb_fill_i;
    logic       rob_store_ack_i;
    gl_index_t  rob_store_gl_idx_i;
    mem_instr_t issue_o;
    logic       issue_ready_i;
    logic       empty_o;
    logic       load_after_store_o;
    int         ready_mode;     // 0 ready, 1 random stalls, 2 stalled

    `include "lsu_ref.svh"

    lsu_top u_lsu_top (.*);

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    function automatic mem_instr_t make_instr(input mem_type_t t, input mem_size_t s,
                                              input addr_t a, input data_t d);
        mem_instr_t m;
        m          = '0;
        m.valid    = 1'b1;
        m.mem_type = t;
        m.mem_size = s;
        m.gl_index = gl_index_t'($urandom);
        m.addr     = a;
        m.data     = d;
        return m;
    endfunction

    // Tasks start and end 1 ns after a rising edge
    task automatic send_instr(input mem_instr_t in);
        instr_i = in;
        do @(posedge clk_i); while (!instr_ready_o);
        #1 instr_i = '0;
    endtask

    task automatic fill_page(input pn_t vpn, input pn_t ppn, input logic rd, input logic wr);
        map_vpn.push_back(vpn);
        map_ppn.push_back(ppn);
        map_rd.push_back(rd);
        map_wr.push_back(wr);
        tlb_fill_i = '{valid: 1'b1, vpn: vpn, ppn: ppn, readable: rd, writable: wr};
        @(posedge clk_i);
        #1 tlb_fill_i = '0;
    endtask

    task automatic expect_no_issue(input int cycles);
        repeat (cycles) begin
            @(posedge clk_i);
            check_flag("issue_o.valid", issue_o.valid, 1'b0);
        end
        #1;
    endtask

    task automatic wait_drain;
        int n;
        n = 0;
        do begin
            @(posedge clk_i);
            n++;
        end while ((exp_q.size() != 0 || !empty_o) && n < 500);
        #1;
        if (n >= 500) report_fail("Queue did not drain in time");
    endtask

    // Ack level held until the store leaves
    task automatic ack_store(input gl_index_t gl);
        rob_store_ack_i    = 1'b1;
        rob_store_gl_idx_i = gl;
        do @(posedge clk_i); while (!(issue_o.valid && issue_ready_i && issue_o.mem_type != LOAD));
        #1 rob_store_ack_i = 1'b0;
    endtask

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    initial begin
        forever begin
            @(posedge clk_i);
            #1;
            case (ready_mode)
                1:       issue_ready_i = ($urandom % 4) != 0;
                2:       issue_ready_i = 1'b0;
                default: issue_ready_i = 1'b1;
            endcase
        end
    end

    // Scoreboard compare on every accepted issue
    always @(posedge clk_i) begin
        if (rstn_i && issue_o.valid && issue_ready_i) begin
            if (exp_q.size() == 0) report_fail("Instruction issued when none was expected");
            else check_instr("issue_o", issue_o, exp_q.pop_front());
        end
    end

    initial begin
        #(WATCHDOG_NS);
        report_fail("Watchdog timeout, the DUT stopped making progress");
    end

    initial begin
        mem_instr_t m;
        mem_instr_t s;
        addr_t      a;
        void'($urandom(93));
        {rstn_i, flush_i, en_translation_i, rob_store_ack_i} = '0;
        {instr_i, tlb_fill_i, rob_store_gl_idx_i} = '0;
        issue_ready_i = 1'b1;
        ready_mode    = 0;
        repeat (5) @(posedge clk_i);
        check_flag("instr_ready_o", instr_ready_o, 1'b0);
        #1 rstn_i = 1'b1;
        @(posedge clk_i);
        check_flag("empty_o", empty_o, 1'b1);
        check_flag("load_after_store_o", load_after_store_o, 1'b0);
        check_flag("issue_o.valid", issue_o.valid, 1'b0);
        check_flag("instr_ready_o", instr_ready_o, 1'b1);
        #1;

        // Untranslated loads under random stalls
        ready_mode = 1;
        repeat (24) begin
            m = make_instr(LOAD, mem_size_t'($urandom % 7), '0, '0);
            a = 32'h1000_0000 + ($urandom % 32'h3000_0000);
            m.addr = a - (a % access_bytes(m.mem_size));
            exp_q.push_back(ref_translate(m, 1'b0));
            send_instr(m);
        end
        wait_drain();
        ready_mode = 0;

        // First touch of each page misses until the fill
        en_translation_i = 1'b1;
        m = make_instr(LOAD, MEM_W, 32'h1234_5ab4, '0);
        send_instr(m);
        expect_no_issue(6);
        fill_page(20'h12345, 20'h80001, 1'b1, 1'b1);
        exp_q.push_back(ref_translate(m, 1'b1));
        wait_drain();
        m = make_instr(LOAD, MEM_D, 32'h2345_6010, '0);
        send_instr(m);
        expect_no_issue(6);
        fill_page(20'h23456, 20'h00042, 1'b1, 1'b0);  // Read only
        exp_q.push_back(ref_translate(m, 1'b1));
        wait_drain();
        m = make_instr(LOAD, MEM_B, 32'h3456_7003, '0);
        send_instr(m);
        expect_no_issue(6);
        fill_page(20'h34567, 20'h00077, 1'b0, 1'b1);  // Write only
        exp_q.push_back(ref_translate(m, 1'b1));
        wait_drain();
        repeat (8) begin
            m = make_instr(LOAD, MEM_W, {20'h12345, 12'($urandom) & 12'hffc}, '0);
            exp_q.push_back(ref_translate(m, 1'b1));
            send_instr(m);
        end
        wait_drain();

        // Exceptions with and without translation
        m = make_instr(STORE, MEM_W, 32'h2345_6020, {$urandom, $urandom});
        exp_q.push_back(ref_translate(m, 1'b1));
        send_instr(m);
        m = make_instr(LOAD, MEM_W, 32'h1234_5002, '0);
        exp_q.push_back(ref_translate(m, 1'b1));
        send_instr(m);
        m = make_instr(AMO, MEM_D, 32'h1234_5104, {$urandom, $urandom});
        exp_q.push_back(ref_translate(m, 1'b1));
        send_instr(m);
        wait_drain();
        en_translation_i = 1'b0;
        m = make_instr(LOAD, MEM_W, 32'h0000_0800, '0);
        exp_q.push_back(ref_translate(m, 1'b0));
        send_instr(m);
        m = make_instr(STORE, MEM_W, 32'h9000_0000, {$urandom, $urandom});
        exp_q.push_back(ref_translate(m, 1'b0));
        send_instr(m);
        m = make_instr(STORE, MEM_H, 32'h9000_0001, {$urandom, $urandom});
        exp_q.push_back(ref_translate(m, 1'b0));
        send_instr(m);
        m = make_instr(LOAD, MEM_WU, 32'h0000_0002, '0);
        exp_q.push_back(ref_translate(m, 1'b0));
        send_instr(m);
        wait_drain();

        // Load behind a buffered store to the same word
        s = make_instr(STORE, MEM_D, 32'h2000_0108, {$urandom, $urandom});
        m = make_instr(LOAD, MEM_W, 32'h2000_010c, '0);
        send_instr(s);
        send_instr(m);
        expect_no_issue(8);
        @(posedge clk_i);
        check_flag("load_after_store_o", load_after_store_o, 1'b1);
        #1;
        exp_q.push_back(ref_translate(s, 1'b0));
        exp_q.push_back(ref_translate(m, 1'b0));
        ack_store(s.gl_index);
        wait_drain();

        // I/O load waits for an empty store buffer
        s = make_instr(STORE, MEM_W, 32'h2000_0200, {$urandom, $urandom});
        m = make_instr(LOAD, MEM_W, 32'h4000_0010, '0);
        send_instr(s);
        send_instr(m);
        expect_no_issue(10);
        @(posedge clk_i);
        check_flag("load_after_store_o", load_after_store_o, 1'b0);
        check_flag("empty_o", empty_o, 1'b0);
        #1;
        exp_q.push_back(ref_translate(s, 1'b0));
        exp_q.push_back(ref_translate(m, 1'b0));
        ack_store(s.gl_index);
        wait_drain();

        // Flushed work never issues
        ready_mode = 2;
        @(posedge clk_i);
        #1;
        repeat (7) send_instr(make_instr(LOAD, MEM_W, 32'h1800_0040, '0));
        send_instr(make_instr(STORE, MEM_W, 32'h1800_0080, {$urandom, $urandom}));
        @(posedge clk_i);
        check_flag("instr_ready_o", instr_ready_o, 1'b0);   // Queue full under stall
        repeat (3) @(posedge clk_i);
        #1 flush_i = 1'b1;
        @(posedge clk_i);
        #1 flush_i = 1'b0;
        @(posedge clk_i);
        check_flag("empty_o", empty_o, 1'b1);
        #1 ready_mode = 0;
        expect_no_issue(20);

        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: lsq/load_store_queue.sv
`timescale 1ns/1ps
/* Load-store queue with in-order translation, issue selection
   and hand-off of translated stores to the store buffer */
module load_store_queue
    import lsq_pkg::*;
(
    input  logic       clk_i,
    input  logic       rstn_i,
    input  logic       flush_i,
    input  mem_instr_t instr_i,
    output logic       instr_ready_o,
    input  logic       issue_ready_i,
    input  logic       rob_store_ack_i,
    input  gl_index_t  rob_store_gl_idx_i,
    output tlb_req_t   tlb_req_o,
    input  tlb_resp_t  tlb_resp_i,
    output mem_instr_t xlate_instr_o,
    input  mem_instr_t translated_i,
    input  logic       en_translation_i,
    output mem_instr_t issue_o,
    output logic       empty_o,
    output logic       load_after_store_o
);

    mem_instr_t lsq_mem [LSQ_NUM_ENTRIES];

    lsq_ptr_t tail_q;       // Next free entry
    lsq_ptr_t xlate_q;      // Oldest untranslated entry
    lsq_ptr_t head_q;       // Oldest translated entry
    lsq_cnt_t untrans_cnt_q;
    lsq_cnt_t ready_cnt_q;

    mem_instr_t head_entry;
    mem_instr_t sb_head;
    logic       lsq_full;
    logic       enq;
    logic       xlate_pending;
    logic       xlate_done;
    logic       head_is_load;
    logic       head_is_store;
    logic       head_xcpt;
    logic       io_load;
    logic       load_ok;
    logic       sb_ack;
    logic       sb_empty;
    logic       sb_full;
    logic       sb_collision;
    logic       sb_write;
    logic       sb_advance;
    logic       sel_sb;
    logic       sel_lsq;
    logic       pop_head;
    logic       hold_q;     // Issue stalled last cycle
    logic       hold_sb_q;  // Source of the stalled issue

    assign lsq_full      = (untrans_cnt_q + ready_cnt_q) == lsq_cnt_t'(LSQ_NUM_ENTRIES);
    assign instr_ready_o = !lsq_full && !flush_i && rstn_i;
    assign enq           = instr_i.valid && instr_ready_o;

    // Translation of the oldest untranslated entry
    assign xlate_pending = untrans_cnt_q != '0;
    always_comb begin
        xlate_instr_o       = lsq_mem[xlate_q];
        xlate_instr_o.valid = xlate_pending;
    end

    assign tlb_req_o.valid     = xlate_pending;
    assign tlb_req_o.vpn       = xlate_instr_o.addr[ADDR_BITS-1:PAGE_OFFSET_BITS];
    assign tlb_req_o.store     = xlate_instr_o.mem_type != LOAD;
    assign tlb_req_o.translate = en_translation_i;

    // Miss retries next cycle
    assign xlate_done = xlate_pending && (tlb_resp_i.hit || !en_translation_i) && !flush_i;

    // Head of the queue
    assign head_entry    = lsq_mem[head_q];
    assign head_is_load  = (ready_cnt_q != '0) && head_entry.mem_type == LOAD;
    assign head_is_store = (ready_cnt_q != '0) && head_entry.mem_type != LOAD;
    assign head_xcpt     = (ready_cnt_q != '0) && head_entry.xcpt.valid;

    assign io_load = head_entry.addr >= IO_ADDR_LOWER && head_entry.addr < IO_ADDR_UPPER;
    assign load_ok = head_is_load && !head_xcpt && !sb_collision && (!io_load || sb_empty);

    assign sb_ack = sb_head.valid && rob_store_ack_i && sb_head.gl_index == rob_store_gl_idx_i;

    assign load_after_store_o = head_is_load && !head_xcpt && sb_collision;

    // Issue priority, a stalled issue keeps its source
    always_comb begin
        sel_sb  = 1'b0;
        sel_lsq = 1'b0;
        if (hold_q) begin
            sel_sb  = hold_sb_q;
            sel_lsq = !hold_sb_q;
        end else if (sb_ack) begin
            sel_sb = 1'b1;
        end else if (head_xcpt || load_ok) begin
            sel_lsq = 1'b1;
        end
    end

    always_comb begin
        issue_o = '0;
        if (flush_i) begin
            issue_o = '0;           // In-flight issue dropped
        end else if (sel_sb) begin
            issue_o = sb_head;
        end else if (sel_lsq) begin
            issue_o = head_entry;
        end
    end

    assign sb_advance = sel_sb && issue_ready_i && !flush_i;
    assign sb_write   = head_is_store && !head_xcpt && !sb_full && issue_ready_i && !flush_i;
    assign pop_head   = (sel_lsq && issue_ready_i && !flush_i) || sb_write;

    assign empty_o = (untrans_cnt_q == '0) && (ready_cnt_q == '0) && sb_empty;

    always_ff @(posedge clk_i) begin
        if (enq) begin
            lsq_mem[tail_q] <= instr_i;
        end
        if (xlate_done) begin
            lsq_mem[xlate_q] <= translated_i;  // Physical address and exception
        end
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            tail_q        <= '0;
            xlate_q       <= '0;
            head_q        <= '0;
            untrans_cnt_q <= '0;
            ready_cnt_q   <= '0;
            hold_q        <= 1'b0;
            hold_sb_q     <= 1'b0;
        end else if (flush_i) begin
            tail_q        <= '0;
            xlate_q       <= '0;
            head_q        <= '0;
            untrans_cnt_q <= '0;
            ready_cnt_q   <= '0;
            hold_q        <= 1'b0;
            hold_sb_q     <= 1'b0;
        end else begin
            tail_q        <= tail_q + lsq_ptr_t'(enq);
            xlate_q       <= xlate_q + lsq_ptr_t'(xlate_done);
            head_q        <= head_q + lsq_ptr_t'(pop_head);
            untrans_cnt_q <= untrans_cnt_q + lsq_cnt_t'(enq) - lsq_cnt_t'(xlate_done);
            ready_cnt_q   <= ready_cnt_q + lsq_cnt_t'(xlate_done) - lsq_cnt_t'(pop_head);
            hold_q        <= issue_o.valid && !issue_ready_i;
            hold_sb_q     <= sel_sb;
        end
    end

    store_buffer u_store_buffer (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .flush_i     (flush_i),
        .write_i     (sb_write),
        .instr_i     (head_entry),
        .advance_i   (sb_advance),
        .load_addr_i (head_entry.addr),
        .head_o      (sb_head),
        .empty_o     (sb_empty),
        .full_o      (sb_full),
        .collision_o (sb_collision)
    );

endmodule

// File: lsq/store_buffer.sv
`timescale 1ns/1ps
/* Store buffer, a FIFO of translated stores waiting for commit,
   with word-granular collision check against the head load */
module store_buffer
    import lsq_pkg::*;
(
    input  logic       clk_i,
    input  logic       rstn_i,
    input  logic       flush_i,
    input  logic       write_i,
    input  mem_instr_t instr_i,
    input  logic       advance_i,
    input  addr_t      load_addr_i,
    output mem_instr_t head_o,
    output logic       empty_o,
    output logic       full_o,
    output logic       collision_o
);

    mem_instr_t sb_mem [SB_NUM_ENTRIES];

    logic [SB_NUM_ENTRIES-1:0] entry_valid_q;
    sb_ptr_t                   head_q;
    sb_ptr_t                   tail_q;

    // Entries stay contiguous, so the valid bits give the fill level
    assign empty_o = ~|entry_valid_q;
    assign full_o  = &entry_valid_q;

    always_comb begin
        head_o       = sb_mem[head_q];
        head_o.valid = entry_valid_q[head_q];
    end

    // Same 8-byte aligned physical word
    always_comb begin
        collision_o = 1'b0;
        for (int i = 0; i < SB_NUM_ENTRIES; i++) begin
            if (entry_valid_q[i] &&
                sb_mem[i].addr[ADDR_BITS-1:3] == load_addr_i[ADDR_BITS-1:3]) begin
                collision_o = 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (write_i && !full_o) begin
            sb_mem[tail_q] <= instr_i;
        end
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            entry_valid_q <= '0;
            head_q        <= '0;
            tail_q        <= '0;
        end else if (flush_i) begin
            entry_valid_q <= '0;
            head_q        <= '0;
            tail_q        <= '0;
        end else begin
            if (write_i && !full_o) begin
                entry_valid_q[tail_q] <= 1'b1;
                tail_q                <= tail_q + sb_ptr_t'(1);
            end
            if (advance_i && !empty_o) begin  // Oldest store leaves
                entry_valid_q[head_q] <= 1'b0;
                head_q                <= head_q + sb_ptr_t'(1);
            end
        end
    end

endmodule

// File: source/dtlb.sv
`timescale 1ns/1ps
/* Fully associative data TLB with fill port and round-robin replacement */
module dtlb
    import lsq_pkg::*;
(
    input  logic      clk_i,
    input  logic      rstn_i,
    input  tlb_req_t  req_i,
    input  tlb_fill_t fill_i,
    output tlb_resp_t resp_o
);

    logic [TLB_NUM_ENTRIES-1:0] entry_valid_q;
    logic [TLB_NUM_ENTRIES-1:0] entry_read_q;
    logic [TLB_NUM_ENTRIES-1:0] entry_write_q;
    pn_t                        entry_vpn_q [TLB_NUM_ENTRIES];
    pn_t                        entry_ppn_q [TLB_NUM_ENTRIES];
    tlb_ptr_t                   repl_ptr_q;   // Next victim

    // Lowest matching entry wins
    always_comb begin
        resp_o = '0;
        if (req_i.valid && req_i.translate) begin
            for (int i = TLB_NUM_ENTRIES - 1; i >= 0; i--) begin
                if (entry_valid_q[i] && entry_vpn_q[i] == req_i.vpn) begin
                    resp_o.hit           = 1'b1;
                    resp_o.ppn           = entry_ppn_q[i];
                    resp_o.ld_page_fault = !req_i.store && !entry_read_q[i];
                    resp_o.st_page_fault = req_i.store && !entry_write_q[i];
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (fill_i.valid) begin
            entry_vpn_q[repl_ptr_q]   <= fill_i.vpn;
            entry_ppn_q[repl_ptr_q]   <= fill_i.ppn;
            entry_read_q[repl_ptr_q]  <= fill_i.readable;
            entry_write_q[repl_ptr_q] <= fill_i.writable;
        end
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            entry_valid_q <= '0;
            repl_ptr_q    <= '0;
        end else if (fill_i.valid) begin
            entry_valid_q[repl_ptr_q] <= 1'b1;
            repl_ptr_q                <= repl_ptr_q + tlb_ptr_t'(1);
        end
    end

endmodule

// File: source/lsu_top.sv
`timescale 1ns/1ps
/* Memory-ordering front end: queue, data TLB and exception check */
module lsu_top
    import lsq_pkg::*;
(
    input  logic       clk_i,
    input  logic       rstn_i,
    input  logic       flush_i,
    input  logic       en_translation_i,
    input  mem_instr_t instr_i,
    output logic       instr_ready_o,
    input  tlb_fill_t  tlb_fill_i,
    input  logic       rob_store_ack_i,
    input  gl_index_t  rob_store_gl_idx_i,
    output mem_instr_t issue_o,
    input  logic       issue_ready_i,
    output logic       empty_o,
    output logic       load_after_store_o
);

    tlb_req_t   tlb_req;
    tlb_resp_t  tlb_resp;
    mem_instr_t xlate_instr;    // Entry under translation
    mem_instr_t translated;     // Same entry with physical address

    load_store_queue u_load_store_queue (
        .clk_i              (clk_i),
        .rstn_i             (rstn_i),
        .flush_i            (flush_i),
        .instr_i            (instr_i),
        .instr_ready_o      (instr_ready_o),
        .issue_ready_i      (issue_ready_i),
        .rob_store_ack_i    (rob_store_ack_i),
        .rob_store_gl_idx_i (rob_store_gl_idx_i),
        .tlb_req_o          (tlb_req),
        .tlb_resp_i         (tlb_resp),
        .xlate_instr_o      (xlate_instr),
        .translated_i       (translated),
        .en_translation_i   (en_translation_i),
        .issue_o            (issue_o),
        .empty_o            (empty_o),
        .load_after_store_o (load_after_store_o)
    );

    dtlb u_dtlb (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .req_i  (tlb_req),
        .fill_i (tlb_fill_i),
        .resp_o (tlb_resp)
    );

    mem_xcpt_check u_mem_xcpt_check (
        .instr_i          (xlate_instr),
        .tlb_resp_i       (tlb_resp),
        .en_translation_i (en_translation_i),
        .instr_o          (translated)
    );

endmodule

// File: source/mem_xcpt_check.sv
`timescale 1ns/1ps
/* Address translation merge and memory exception decode */
module mem_xcpt_check
    import lsq_pkg::*;
(
    input  mem_instr_t instr_i,
    input  tlb_resp_t  tlb_resp_i,
    input  logic       en_translation_i,
    output mem_instr_t instr_o
);

    logic       is_store;
    logic [2:0] align_mask;
    logic       misaligned;
    logic       bad_phys;

    assign is_store = instr_i.mem_type != LOAD;   // AMO counts as store

    always_comb begin
        case (instr_i.mem_size)
            MEM_H, MEM_HU: align_mask = 3'b001;
            MEM_W, MEM_WU: align_mask = 3'b011;
            MEM_D:         align_mask = 3'b111;
            default:       align_mask = 3'b000;
        endcase
    end

    assign misaligned = |(instr_i.addr[2:0] & align_mask);

    // Only untranslated addresses are checked against the map
    assign bad_phys = !en_translation_i &&
                      (instr_i.addr < UNMAPPED_ADDR_UPPER || instr_i.addr >= PHYS_MEM_LIMIT);

    always_comb begin
        instr_o            = instr_i;
        instr_o.translated = !en_translation_i || tlb_resp_i.hit;
        if (en_translation_i) begin
            instr_o.addr = {tlb_resp_i.ppn, instr_i.addr[PAGE_OFFSET_BITS-1:0]};
        end
        instr_o.xcpt.valid  = 1'b1;
        instr_o.xcpt.origin = instr_i.addr;
        if (misaligned) begin
            instr_o.xcpt.cause = is_store ? ST_AMO_ADDR_MISALIGNED : LD_ADDR_MISALIGNED;
        end else if (is_store && tlb_resp_i.st_page_fault) begin
            instr_o.xcpt.cause = ST_AMO_PAGE_FAULT;
        end else if (tlb_resp_i.ld_page_fault) begin
            instr_o.xcpt.cause = LD_PAGE_FAULT;
        end else if (bad_phys) begin
            instr_o.xcpt.cause = is_store ? ST_AMO_ACCESS_FAULT : LD_ACCESS_FAULT;
        end else begin
            instr_o.xcpt = '0;
        end
    end

endmodule
